//--- proc_pkg.sv
`default_nettype none

package proc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  wb_sel_t;
    typedef logic [1:0]  mem_width_t;

    // ALU operations
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_SLT  = 4'd5;
    localparam alu_op_t ALU_PASS = 4'd6;

    // Writeback sources
    localparam wb_sel_t WB_LINK = 2'b01;
    localparam wb_sel_t WB_MEM  = 2'b10;
    localparam wb_sel_t WB_ALU  = 2'b11;

    localparam mem_width_t WIDTH_BYTE = 2'b00;
    localparam mem_width_t WIDTH_WORD = 2'b10;

    // Major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_CUSTOM = 7'b0001011;

    localparam logic [2:0] FN3_ADD = 3'b000;
    localparam logic [2:0] FN3_SLT = 3'b010;
    localparam logic [2:0] FN3_XOR = 3'b100;
    localparam logic [2:0] FN3_OR  = 3'b110;
    localparam logic [2:0] FN3_AND = 3'b111;
    localparam logic [6:0] FN7_SUB = 7'b0100000;

    localparam logic [2:0] FN3_BEQ = 3'b000;
    localparam logic [2:0] FN3_BNE = 3'b001;
    localparam logic [2:0] FN3_LB  = 3'b000;
    localparam logic [2:0] FN3_LW  = 3'b010;
    localparam logic [2:0] FN3_LBU = 3'b100;
    localparam logic [2:0] FN3_SB  = 3'b000;
    localparam logic [2:0] FN3_SW  = 3'b010;

    // Custom-0 strobe select
    localparam logic [2:0] FN3_SAC = 3'b000;
    localparam logic [2:0] FN3_SND = 3'b001;
    localparam logic [2:0] FN3_UAD = 3'b010;
    localparam logic [2:0] FN3_PPU = 3'b011;

endpackage

`default_nettype wire

//--- proc_if.sv
`timescale 1ns/10ps
`default_nettype none

// Decode to execute stage register contents
interface dec_ex_if
    import proc_pkg::*;
();
    logic       valid;
    word_t      pc;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    reg_addr_t  rd;
    alu_op_t    alu_op;
    logic       use_imm;
    logic       reg_wen;
    logic       mem_ren;
    logic       mem_wen;
    mem_width_t width;
    logic       load_unsigned;
    logic       branch;
    logic       branch_ne;
    logic       jump;
    wb_sel_t    wb_sel;

    modport src (output valid, pc, rs1_data, rs2_data, imm, rd, alu_op, use_imm, reg_wen,
                 mem_ren, mem_wen, width, load_unsigned, branch, branch_ne, jump, wb_sel);
    modport dst (input valid, pc, rs1_data, rs2_data, imm, rd, alu_op, use_imm, reg_wen,
                 mem_ren, mem_wen, width, load_unsigned, branch, branch_ne, jump, wb_sel);
endinterface

// Execute to result stage register contents
interface ex_res_if
    import proc_pkg::*;
();
    logic       valid;
    word_t      alu_result;
    word_t      store_data;
    word_t      link_pc;
    reg_addr_t  rd;
    logic       reg_wen;
    logic       mem_ren;
    logic       mem_wen;
    mem_width_t width;
    logic       load_unsigned;
    wb_sel_t    wb_sel;

    modport src (output valid, alu_result, store_data, link_pc, rd, reg_wen, mem_ren,
                 mem_wen, width, load_unsigned, wb_sel);
    modport dst (input valid, alu_result, store_data, link_pc, rd, reg_wen, mem_ren,
                 mem_wen, width, load_unsigned, wb_sel);
endinterface

`default_nettype wire

//--- fetch.sv
`timescale 1ns/10ps
`default_nettype none

module fetch
    import proc_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  redirect,
    input  word_t redirect_pc,
    output word_t imem_addr,
    input  word_t imem_data,
    output word_t instr,
    output word_t instr_pc,
    output logic  instr_valid
);

    word_t pc;

    assign imem_addr = pc;

    // Redirect wins over the sequential pc and kills the fetched slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= RESET_PC;
            instr_valid <= 1'b0;
        end else begin
            pc          <= redirect ? redirect_pc : pc + 32'd4;
            instr_valid <= ~redirect;
        end
    end

    always_ff @(posedge clk) begin
        instr    <= imem_data;
        instr_pc <= pc;
    end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file
    import proc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      wen,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-first bypass so a same-cycle reader sees the new value
    assign rs1_data = (rs1 == 5'd0) ? '0 : (wen && waddr == rs1) ? wdata : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : (wen && waddr == rs2) ? wdata : regs[rs2];

endmodule

`default_nettype wire

//--- decode.sv
`timescale 1ns/10ps
`default_nettype none

module decode
    import proc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     instr,
    input  word_t     instr_pc,
    input  logic      instr_valid,
    input  logic      redirect,
    input  logic      wb_en,
    input  reg_addr_t wb_reg,
    input  word_t     wb_data,
    dec_ex_if.src     dx,
    output logic      sac,
    output logic      snd,
    output logic      uad,
    output logic      ppu_send,
    output word_t     interface_data
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rs1, rs2, rd;
    word_t      rs1_data, rs2_data;
    word_t      imm_i, imm_s, imm_b, imm_j, imm;
    alu_op_t    alu_op;
    mem_width_t width;
    wb_sel_t    wb_sel;
    logic       legal, use_imm, reg_wen, mem_ren, mem_wen, load_unsigned;
    logic       branch, branch_ne, jump, custom, fire;
    logic [3:0] strobe;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    reg_file regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wen     (wb_en),
        .waddr   (wb_reg),
        .wdata   (wb_data)
    );

    always_comb begin
        legal         = 1'b0;
        alu_op        = ALU_ADD;
        use_imm       = 1'b0;
        reg_wen       = 1'b0;
        mem_ren       = 1'b0;
        mem_wen       = 1'b0;
        width         = WIDTH_WORD;
        load_unsigned = 1'b0;
        branch        = 1'b0;
        branch_ne     = 1'b0;
        jump          = 1'b0;
        custom        = 1'b0;
        wb_sel        = WB_ALU;
        imm           = imm_i;
        case (opcode)
            OP_REG: begin
                reg_wen = 1'b1;
                legal   = (funct7 == 7'd0) || (funct7 == FN7_SUB && funct3 == FN3_ADD);
                case (funct3)
                    FN3_ADD: alu_op = (funct7 == FN7_SUB) ? ALU_SUB : ALU_ADD;
                    FN3_SLT: alu_op = ALU_SLT;
                    FN3_XOR: alu_op = ALU_XOR;
                    FN3_OR:  alu_op = ALU_OR;
                    FN3_AND: alu_op = ALU_AND;
                    default: legal = 1'b0;
                endcase
            end
            OP_IMM: begin
                // Only ADDI in this subset
                legal   = (funct3 == FN3_ADD);
                reg_wen = 1'b1;
                use_imm = 1'b1;
            end
            OP_LOAD: begin
                legal         = (funct3 == FN3_LB) || (funct3 == FN3_LW) || (funct3 == FN3_LBU);
                reg_wen       = 1'b1;
                mem_ren       = 1'b1;
                use_imm       = 1'b1;
                wb_sel        = WB_MEM;
                width         = (funct3 == FN3_LW) ? WIDTH_WORD : WIDTH_BYTE;
                load_unsigned = (funct3 == FN3_LBU);
            end
            OP_STORE: begin
                legal   = (funct3 == FN3_SB) || (funct3 == FN3_SW);
                mem_wen = 1'b1;
                use_imm = 1'b1;
                imm     = imm_s;
                width   = (funct3 == FN3_SB) ? WIDTH_BYTE : WIDTH_WORD;
            end
            OP_BRANCH: begin
                legal     = (funct3 == FN3_BEQ) || (funct3 == FN3_BNE);
                branch    = 1'b1;
                branch_ne = (funct3 == FN3_BNE);
                imm       = imm_b;
            end
            OP_JAL: begin
                legal   = 1'b1;
                jump    = 1'b1;
                reg_wen = 1'b1;
                wb_sel  = WB_LINK;
                alu_op  = ALU_PASS;
                imm     = imm_j;
            end
            OP_CUSTOM: begin
                legal  = 1'b1;
                custom = 1'b1;
                alu_op = ALU_PASS;
            end
            default: ;
        endcase
    end

    // Strobe select for the external devices
    assign fire = instr_valid && custom && !redirect;

    always_comb begin
        strobe = 4'b0000;
        if (fire) begin
            case (funct3)
                FN3_SAC: strobe[0] = 1'b1;
                FN3_SND: strobe[1] = 1'b1;
                FN3_UAD: strobe[2] = 1'b1;
                FN3_PPU: strobe[3] = 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sac            <= 1'b0;
            snd            <= 1'b0;
            uad            <= 1'b0;
            ppu_send       <= 1'b0;
            interface_data <= '0;
            dx.valid       <= 1'b0;
        end else begin
            sac      <= strobe[0];
            snd      <= strobe[1];
            uad      <= strobe[2];
            ppu_send <= strobe[3];
            // Data holds its last value between strobes
            if (|strobe) begin
                interface_data <= rs1_data;
            end
            dx.valid <= instr_valid && legal && !redirect;
        end
    end

    always_ff @(posedge clk) begin
        dx.pc            <= instr_pc;
        dx.rs1_data      <= rs1_data;
        dx.rs2_data      <= rs2_data;
        dx.imm           <= imm;
        dx.rd            <= rd;
        dx.alu_op        <= alu_op;
        dx.use_imm       <= use_imm;
        dx.reg_wen       <= reg_wen;
        dx.mem_ren       <= mem_ren;
        dx.mem_wen       <= mem_wen;
        dx.width         <= width;
        dx.load_unsigned <= load_unsigned;
        dx.branch        <= branch;
        dx.branch_ne     <= branch_ne;
        dx.jump          <= jump;
        dx.wb_sel        <= wb_sel;
    end

endmodule

`default_nettype wire

//--- execute.sv
`timescale 1ns/10ps
`default_nettype none

module execute
    import proc_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    dec_ex_if.dst dx,
    ex_res_if.src xr,
    output logic  redirect,
    output word_t redirect_pc
);

    word_t op_b;
    word_t alu_result;
    logic  taken;

    assign op_b = dx.use_imm ? dx.imm : dx.rs2_data;

    always_comb begin
        case (dx.alu_op)
            ALU_ADD:  alu_result = dx.rs1_data + op_b;
            ALU_SUB:  alu_result = dx.rs1_data - op_b;
            ALU_AND:  alu_result = dx.rs1_data & op_b;
            ALU_OR:   alu_result = dx.rs1_data | op_b;
            ALU_XOR:  alu_result = dx.rs1_data ^ op_b;
            ALU_SLT:  alu_result = {31'd0, $signed(dx.rs1_data) < $signed(op_b)};
            ALU_PASS: alu_result = dx.imm;
            default:  alu_result = dx.rs1_data + op_b;
        endcase
    end

    // BNE inverts the equality test
    assign taken       = dx.branch && ((dx.rs1_data == dx.rs2_data) != dx.branch_ne);
    assign redirect    = dx.valid && (dx.jump || taken);
    assign redirect_pc = dx.pc + dx.imm;

    // Flushed slots arrive here already invalid from decode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xr.valid <= 1'b0;
        end else begin
            xr.valid <= dx.valid;
        end
    end

    always_ff @(posedge clk) begin
        xr.alu_result    <= alu_result;
        xr.store_data    <= dx.rs2_data;
        xr.link_pc       <= dx.pc + 32'd4;
        xr.rd            <= dx.rd;
        xr.reg_wen       <= dx.reg_wen;
        xr.mem_ren       <= dx.mem_ren;
        xr.mem_wen       <= dx.mem_wen;
        xr.width         <= dx.width;
        xr.load_unsigned <= dx.load_unsigned;
        xr.wb_sel        <= dx.wb_sel;
    end

endmodule

`default_nettype wire

//--- result.sv
`timescale 1ns/10ps
`default_nettype none

module result
    import proc_pkg::*;
#(
    parameter int DMEM_WORDS = 64
) (
    input  logic      clk,
    input  logic      rst_n,
    ex_res_if.dst     xr,
    output logic      wb_en,
    output reg_addr_t wb_reg,
    output word_t     wb_data
);

    // Depth is a power of two so the index slice wraps the address
    localparam int AW = $clog2(DMEM_WORDS);

    word_t          dmem [DMEM_WORDS];
    logic [AW-1:0]  word_idx;
    logic [1:0]     lane;
    word_t          rd_word;
    logic [7:0]     rd_byte;
    word_t          load_val;
    word_t          load_q, alu_q, link_q;
    wb_sel_t        wb_sel_q;

    assign word_idx = xr.alu_result[AW+1:2];
    assign lane     = xr.alu_result[1:0];

    // Byte store touches one lane only
    always_ff @(posedge clk) begin
        if (xr.valid && xr.mem_wen) begin
            if (xr.width == WIDTH_BYTE) begin
                dmem[word_idx][{lane, 3'b000} +: 8] <= xr.store_data[7:0];
            end else begin
                dmem[word_idx] <= xr.store_data;
            end
        end
    end

    assign rd_word = dmem[word_idx];
    assign rd_byte = rd_word[{lane, 3'b000} +: 8];

    always_comb begin
        if (xr.width == WIDTH_BYTE) begin
            load_val = xr.load_unsigned ? {24'd0, rd_byte} : {{24{rd_byte[7]}}, rd_byte};
        end else begin
            load_val = rd_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= xr.valid && xr.reg_wen && (xr.rd != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (xr.valid && xr.mem_ren) begin
            load_q <= load_val;
        end
        alu_q    <= xr.alu_result;
        link_q   <= xr.link_pc;
        wb_reg   <= xr.rd;
        wb_sel_q <= xr.wb_sel;
    end

    // Writeback select
    always_comb begin
        case (wb_sel_q)
            WB_LINK: wb_data = link_q;
            WB_MEM:  wb_data = load_q;
            default: wb_data = alu_q;
        endcase
    end

endmodule

`default_nettype wire

//--- proc.sv
`timescale 1ns/10ps
`default_nettype none

module proc
    import proc_pkg::*;
#(
    parameter int    DMEM_WORDS = 64,
    parameter word_t RESET_PC   = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  rst_n,
    output word_t imem_addr,
    input  word_t imem_data,
    output logic  sac,
    output logic  snd,
    output logic  uad,
    output logic  ppu_send,
    output word_t interface_data
);

    // Fetch to decode
    word_t     instr, instr_pc;
    logic      instr_valid;

    // Branch redirect from execute
    logic      redirect;
    word_t     redirect_pc;

    // Writeback into the register file
    logic      wb_en;
    reg_addr_t wb_reg;
    word_t     wb_data;

    dec_ex_if dx_bus ();
    ex_res_if xr_bus ();

    fetch #(
        .RESET_PC(RESET_PC)
    ) proc_fe (
        .clk        (clk),
        .rst_n      (rst_n),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .instr      (instr),
        .instr_pc   (instr_pc),
        .instr_valid(instr_valid)
    );

    decode proc_de (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr         (instr),
        .instr_pc      (instr_pc),
        .instr_valid   (instr_valid),
        .redirect      (redirect),
        .wb_en         (wb_en),
        .wb_reg        (wb_reg),
        .wb_data       (wb_data),
        .dx            (dx_bus),
        .sac           (sac),
        .snd           (snd),
        .uad           (uad),
        .ppu_send      (ppu_send),
        .interface_data(interface_data)
    );

    execute proc_ex (
        .clk        (clk),
        .rst_n      (rst_n),
        .dx         (dx_bus),
        .xr         (xr_bus),
        .redirect   (redirect),
        .redirect_pc(redirect_pc)
    );

    result #(
        .DMEM_WORDS(DMEM_WORDS)
    ) proc_res (
        .clk    (clk),
        .rst_n  (rst_n),
        .xr     (xr_bus),
        .wb_en  (wb_en),
        .wb_reg (wb_reg),
        .wb_data(wb_data)
    );

endmodule

`default_nettype wire

//--- proc_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module proc_asserts
    import proc_pkg::*;
(
    input wire logic  clk,
    input wire logic  rst_n,
    input wire word_t imem_addr,
    input wire logic  redirect,
    input wire logic  wb_en,
    input wire logic  sac,
    input wire logic  snd,
    input wire logic  uad,
    input wire logic  ppu_send
);

    // Device strobes are mutually exclusive
    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({sac, snd, uad, ppu_send}))
        else $error("more than one device strobe high in the same cycle");

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !(sac || snd || uad || ppu_send || wb_en))
        else $error("strobe or register write active during reset");

    // The slot behind a redirect is always flushed
    a_redirect_single: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> !redirect)
        else $error("redirect high in two consecutive cycles");

    a_pc_step: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n) && !$past(redirect)) |-> imem_addr == $past(imem_addr) + 32'd4)
        else $error("fetch address did not advance by 4");

endmodule

bind proc proc_asserts proc_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .imem_addr(imem_addr),
    .redirect (redirect),
    .wb_en    (wb_en),
    .sac      (sac),
    .snd      (snd),
    .uad      (uad),
    .ppu_send (ppu_send)
);

`default_nettype wire

//--- proc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module proc_tb
    import proc_pkg::*;
();

    localparam int    DMEM_WORDS     = 64;
    localparam word_t RESET_PC       = 32'h0000_0000;
    localparam int    N_TESTS        = 8;
    localparam int    BODY_GROUPS    = 40;
    localparam int    TIMEOUT_CYCLES = 3000;
    localparam int    MAX_STEPS      = 2000;
    localparam word_t NOP            = {12'd0, 5'd0, 3'b000, 5'd0, OP_IMM};

    logic  clk;
    logic  rst_n;
    word_t imem_addr;
    word_t imem_data;
    logic  sac;
    logic  snd;
    logic  uad;
    logic  ppu_send;
    word_t interface_data;

    word_t      imem [512];
    logic [8:0] wp;
    int         ngroups;
    logic [3:0] exp_kind [$];
    word_t      exp_data [$];
    logic [3:0] hit;
    int         obs_count;
    int         errors;
    int         passed;
    int         cur_test;

    proc #(
        .DMEM_WORDS(DMEM_WORDS),
        .RESET_PC  (RESET_PC)
    ) UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .sac           (sac),
        .snd           (snd),
        .uad           (uad),
        .ppu_send      (ppu_send),
        .interface_data(interface_data)
    );

    // Combinational instruction memory
    assign imem_data = imem[imem_addr[10:2]];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic reg_addr_t rnd_reg();
        word_t r;
        r = $urandom % 31 + 1;
        return r[4:0];
    endfunction

    function automatic string kind_name(int kind);
        case (kind)
            0:       return "alu";
            1:       return "memory";
            2:       return "control";
            3:       return "custom";
            default: return "mixed";
        endcase
    endfunction

    task automatic put(word_t ins);
        imem[wp] = ins;
        wp = wp + 9'd1;
    endtask

    // One instruction plus two fill slots, SAC fills behind control flow
    task automatic group(word_t ins, logic sac_fill);
        word_t r;
        put(ins);
        for (int k = 0; k < 2; k++) begin
            r = $urandom;
            put(sac_fill ? enc_i(12'd0, r[4:0], FN3_SAC, 5'd0, OP_CUSTOM) : NOP);
        end
        ngroups++;
    endtask

    task automatic gen_program(int kind);
        word_t      r;
        word_t      off;
        reg_addr_t  ra;
        reg_addr_t  rb;
        reg_addr_t  rd;
        logic [2:0] f3;
        logic [6:0] f7;
        int         cat;
        int         tgt;
        int         last;
        imem = '{default: NOP};
        wp = '0;
        ngroups = 0;
        // Seed every register, then every data word in the test window
        for (int i = 1; i < 32; i++) begin
            r = $urandom;
            group(enc_i(r[11:0], 5'd0, FN3_ADD, i[4:0], OP_IMM), 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            off = i * 4;
            group(enc_s(off[11:0], rnd_reg(), 5'd0, FN3_SW), 1'b0);
        end
        last = ngroups + BODY_GROUPS;
        for (int n = 0; n < BODY_GROUPS; n++) begin
            r = $urandom;
            cat = (kind >= 4) ? int'(r[1:0]) : (r[2] ? kind : 0);
            ra = rnd_reg();
            rb = rnd_reg();
            rd = rnd_reg();
            r = $urandom;
            case (cat)
                0: begin
                    f3 = FN3_ADD;
                    f7 = 7'd0;
                    case (r[6:4])
                        3'd1:    f7 = FN7_SUB;
                        3'd2:    f3 = FN3_SLT;
                        3'd3:    f3 = FN3_XOR;
                        3'd4:    f3 = FN3_OR;
                        3'd5:    f3 = FN3_AND;
                        default: ;
                    endcase
                    if (r[3]) begin
                        group(enc_i(r[19:8], ra, FN3_ADD, rd, OP_IMM), 1'b0);
                    end else begin
                        group(enc_r(f7, rb, ra, f3, rd, OP_REG), 1'b0);
                    end
                end
                1: begin
                    case (r[2:0])
                        3'd0, 3'd1:
                            group(enc_s({7'd0, r[12:10], 2'b00}, rb, 5'd0, FN3_SW), 1'b0);
                        3'd2, 3'd3:
                            group(enc_s({7'd0, r[14:10]}, rb, 5'd0, FN3_SB), 1'b0);
                        3'd4:
                            group(enc_i({7'd0, r[12:10], 2'b00}, 5'd0, FN3_LW, rd, OP_LOAD),
                                  1'b0);
                        3'd5:
                            group(enc_i({7'd0, r[14:10]}, 5'd0, FN3_LB, rd, OP_LOAD), 1'b0);
                        default:
                            group(enc_i({7'd0, r[14:10]}, 5'd0, FN3_LBU, rd, OP_LOAD), 1'b0);
                    endcase
                end
                2: begin
                    // Forward target on a group boundary, at most the epilogue start
                    tgt = ngroups + 1 + int'(r[1:0]);
                    if (tgt > last) begin
                        tgt = last;
                    end
                    off = (tgt - ngroups) * 12;
                    if (r[2]) begin
                        group(enc_j(off[20:0], rd), 1'b1);
                    end else begin
                        group(enc_b(off[12:0], r[3] ? ra : rb, ra,
                                    r[4] ? FN3_BNE : FN3_BEQ), 1'b1);
                    end
                end
                default: group(enc_i(12'd0, r[9:5], {1'b0, r[11:10]}, 5'd0, OP_CUSTOM), 1'b0);
            endcase
        end
        for (int i = 1; i < 32; i++) begin
            group(enc_i(12'd0, i[4:0], FN3_SND, 5'd0, OP_CUSTOM), 1'b0);
        end
        // Self loop parks the core
        put(enc_j(21'd0, 5'd0));
    endtask

    // ISA model of the program, collects the expected strobe events
    function automatic void ref_run();
        word_t      x [32];
        word_t      dm [DMEM_WORDS];
        word_t      pc, w, a, b, v, addr, ld, nxt;
        word_t      imm_i, imm_s, imm_b, imm_j;
        logic [5:0] wi;
        logic [7:0] by;
        logic       wr;
        x = '{default: '0};
        dm = '{default: '0};
        exp_kind.delete();
        exp_data.delete();
        pc = RESET_PC;
        for (int step = 0; step < MAX_STEPS; step++) begin
            w = imem[pc[10:2]];
            a = x[w[19:15]];
            b = x[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            addr = a + ((w[6:0] == OP_STORE) ? imm_s : imm_i);
            // 64 words, so address bits 7:2 pick the word
            wi = addr[7:2];
            ld = dm[wi];
            by = ld[{addr[1:0], 3'b000} +: 8];
            nxt = pc + 32'd4;
            wr = 1'b0;
            v = '0;
            case (w[6:0])
                OP_REG: begin
                    wr = 1'b1;
                    case (w[14:12])
                        FN3_ADD: v = w[30] ? a - b : a + b;
                        FN3_SLT: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN3_XOR: v = a ^ b;
                        FN3_OR:  v = a | b;
                        default: v = a & b;
                    endcase
                end
                OP_IMM: begin
                    wr = 1'b1;
                    v = a + imm_i;
                end
                OP_LOAD: begin
                    wr = 1'b1;
                    case (w[14:12])
                        FN3_LW:  v = ld;
                        FN3_LB:  v = {{24{by[7]}}, by};
                        default: v = {24'd0, by};
                    endcase
                end
                OP_STORE: begin
                    if (w[14:12] == FN3_SW) begin
                        dm[wi] = b;
                    end else begin
                        dm[wi][{addr[1:0], 3'b000} +: 8] = b[7:0];
                    end
                end
                OP_BRANCH: begin
                    if ((a == b) == (w[14:12] == FN3_BEQ)) begin
                        nxt = pc + imm_b;
                    end
                end
                OP_JAL: begin
                    if (imm_j == '0) begin
                        break;
                    end
                    wr = 1'b1;
                    v = pc + 32'd4;
                    nxt = pc + imm_j;
                end
                OP_CUSTOM: begin
                    exp_kind.push_back(4'b0001 << w[13:12]);
                    exp_data.push_back(a);
                end
                default: ;
            endcase
            if (wr && w[11:7] != 5'd0) begin
                x[w[11:7]] = v;
            end
            pc = nxt;
        end
    endfunction

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: test %0d %s got %h expected %h",
                     $time, cur_test, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_strobe(logic [3:0] got, logic [3:0] exp, int idx);
        if (got !== exp) begin
            $display("Mismatch at %0t: test %0d event %0d strobes {ppu,uad,snd,sac} %s %b %s %b",
                     $time, cur_test, idx, "got", got, "expected", exp);
            errors++;
        end
    endtask

    // Event checker, samples registered outputs mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            hit = {ppu_send, uad, snd, sac};
            if (hit != 4'b0000) begin
                if (obs_count < exp_kind.size()) begin
                    check_strobe(hit, exp_kind[obs_count], obs_count);
                    check_word(interface_data, exp_data[obs_count],
                               $sformatf("event %0d interface_data", obs_count));
                end else begin
                    $display("Test %0d: unexpected strobe at %0t beyond the %0d expected events",
                             cur_test, $time, exp_kind.size());
                    errors++;
                end
                obs_count++;
            end else if (obs_count == 0) begin
                check_word(interface_data, 32'd0, "interface_data before first strobe");
            end
        end
    end

    task automatic run_test(int t);
        int cyc;
        int errs_before;
        int kind;
        kind = (t < 4) ? t : 4;
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        cur_test = t;
        gen_program(kind);
        ref_run();
        obs_count = 0;
        errs_before = errors;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        cyc = 0;
        while (obs_count < exp_kind.size() && cyc < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cyc++;
        end
        if (obs_count < exp_kind.size()) begin
            $display("Test %0d: timed out after %0d cycles, expected event count %0d %s %0d",
                     t, cyc, exp_kind.size(), "not reached, saw", obs_count);
            errors++;
        end
        // Idle window to catch stray strobes
        cyc = 0;
        while (cyc < 20) begin
            @(posedge clk);
            cyc++;
        end
        if (errors == errs_before) begin
            passed++;
        end
        $display("Test %0d %s: %0d events, %s", t, kind_name(kind), exp_kind.size(),
                 (errors == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        imem = '{default: NOP};
        rst_n = 1'b0;
        errors = 0;
        passed = 0;
        obs_count = 0;
        cur_test = 0;
        void'($urandom(40));
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 N_TESTS, passed, N_TESTS - passed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
proc_pkg.sv
proc_if.sv
fetch.sv
reg_file.sv
decode.sv
execute.sv
result.sv
proc.sv
proc_asserts.sv
proc_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module proc_tb -f sim.f --Mdir obj_dir
	./obj_dir/Vproc_tb | tee sim.log
	@if grep -q "Some tests failed" sim.log; then exit 1; fi
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
